// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

	// datapath widths
	localparam int DATA_W  = 32;
	localparam int REG_AW  = 5;
	localparam int ALUC_W  = 4;
	localparam int SHAMT_W = 5;

	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;

	// function field of r-type words
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;

	// alu control codes with bit 3 set only for sra
	localparam logic [ALUC_W-1:0] ALUC_ADD = 4'b0000;
	localparam logic [ALUC_W-1:0] ALUC_SUB = 4'b0100;
	localparam logic [ALUC_W-1:0] ALUC_AND = 4'b0001;
	localparam logic [ALUC_W-1:0] ALUC_OR  = 4'b0101;
	localparam logic [ALUC_W-1:0] ALUC_XOR = 4'b0010;
	localparam logic [ALUC_W-1:0] ALUC_LUI = 4'b0110;
	localparam logic [ALUC_W-1:0] ALUC_SLL = 4'b0011;
	localparam logic [ALUC_W-1:0] ALUC_SRL = 4'b0111;
	localparam logic [ALUC_W-1:0] ALUC_SRA = 4'b1111;

	typedef struct packed {
		logic [5:0]         op;
		logic [REG_AW-1:0]  rs;
		logic [REG_AW-1:0]  rt;
		logic [REG_AW-1:0]  rd;
		logic [SHAMT_W-1:0] shamt;
		logic [5:0]         funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]        op;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [15:0]       imm;
	} i_fmt_t;

	// same 32-bit word seen as either format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_t;

endpackage

// ==== rtl/pipe_if.sv ====
`timescale 1ns/1ps

// id/ex pipeline register contents
interface id_ex_if;
	logic                         valid;
	logic [pipe_pkg::REG_AW-1:0]  rn;
	logic [pipe_pkg::ALUC_W-1:0]  aluc;
	logic                         aluimm;
	logic [pipe_pkg::DATA_W-1:0]  a;
	logic [pipe_pkg::DATA_W-1:0]  b;
	logic [pipe_pkg::DATA_W-1:0]  imm;

	modport src (output valid, rn, aluc, aluimm, a, b, imm);
	modport dst (input valid, rn, aluc, aluimm, a, b, imm);
endinterface

// forwarding sources from exe, mem and wb
interface bypass_if;
	logic                         e_wr;
	logic [pipe_pkg::REG_AW-1:0]  e_rn;
	logic [pipe_pkg::DATA_W-1:0]  e_d;
	logic                         m_wr;
	logic [pipe_pkg::REG_AW-1:0]  m_rn;
	logic [pipe_pkg::DATA_W-1:0]  m_d;
	logic                         w_wr;
	logic [pipe_pkg::REG_AW-1:0]  w_rn;
	logic [pipe_pkg::DATA_W-1:0]  w_d;

	modport src (
		output e_wr, e_rn, e_d,
		output m_wr, m_rn, m_d,
		output w_wr, w_rn, w_d
	);
	modport dst (
		input e_wr, e_rn, e_d,
		input m_wr, m_rn, m_d,
		input w_wr, w_rn, w_d
	);
endinterface

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  logic [pipe_pkg::DATA_W-1:0] i_a,
	input  logic [pipe_pkg::DATA_W-1:0] i_b,
	input  logic [pipe_pkg::ALUC_W-1:0] i_aluc,
	output logic [pipe_pkg::DATA_W-1:0] o_r
);

	logic [pipe_pkg::SHAMT_W-1:0] sa;

	// shift count is the low bits of a
	assign sa = i_a[pipe_pkg::SHAMT_W-1:0];

	always_comb
	begin
		case (i_aluc)
			pipe_pkg::ALUC_ADD: o_r = i_a + i_b;
			pipe_pkg::ALUC_SUB: o_r = i_a - i_b;
			pipe_pkg::ALUC_AND: o_r = i_a & i_b;
			pipe_pkg::ALUC_OR:  o_r = i_a | i_b;
			pipe_pkg::ALUC_XOR: o_r = i_a ^ i_b;
			pipe_pkg::ALUC_LUI: o_r = i_b << 16;
			pipe_pkg::ALUC_SLL: o_r = i_b << sa;
			pipe_pkg::ALUC_SRL: o_r = i_b >> sa;
			pipe_pkg::ALUC_SRA: o_r = $signed(i_b) >>> sa;
			default:            o_r = '0;
		endcase
	end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                        clock,
	input  logic                        clrn,
	input  logic [pipe_pkg::REG_AW-1:0] i_rna,
	input  logic [pipe_pkg::REG_AW-1:0] i_rnb,
	input  logic                        i_we,
	input  logic [pipe_pkg::REG_AW-1:0] i_wn,
	input  logic [pipe_pkg::DATA_W-1:0] i_d,
	output logic [pipe_pkg::DATA_W-1:0] o_qa,
	output logic [pipe_pkg::DATA_W-1:0] o_qb
);

	// r0 is not stored
	logic [pipe_pkg::DATA_W-1:0] regs [1:31];

	// write-through so a read in the write cycle sees the new value
	assign o_qa = (i_rna == '0) ? '0 : (i_we && i_wn == i_rna) ? i_d : regs[i_rna];
	assign o_qb = (i_rnb == '0) ? '0 : (i_we && i_wn == i_rnb) ? i_d : regs[i_rnb];

	always_ff @(posedge clock or negedge clrn)
	begin
		if (!clrn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (i_we)
		begin
			// i_we never comes with i_wn of zero
			regs[i_wn] <= i_d;
		end
	end

endmodule

// ==== rtl/ctrl_decode.sv ====
`timescale 1ns/1ps

module ctrl_decode (
	input  pipe_pkg::inst_t             i_inst,
	output logic [pipe_pkg::ALUC_W-1:0] o_aluc,
	output logic                        o_aluimm,
	output logic                        o_shift,
	output logic                        o_regrt,
	output logic                        o_sext,
	output logic                        o_wreg
);

	always_comb
	begin
		// defaults give a no-op
		o_aluc   = pipe_pkg::ALUC_ADD;
		o_aluimm = 1'b0;
		o_shift  = 1'b0;
		o_regrt  = 1'b0;
		o_sext   = 1'b0;
		o_wreg   = 1'b0;
		case (i_inst.r.op)
			pipe_pkg::OP_RTYPE:
			begin
				o_wreg = 1'b1;
				case (i_inst.r.funct)
					pipe_pkg::FN_ADD: o_aluc = pipe_pkg::ALUC_ADD;
					pipe_pkg::FN_SUB: o_aluc = pipe_pkg::ALUC_SUB;
					pipe_pkg::FN_AND: o_aluc = pipe_pkg::ALUC_AND;
					pipe_pkg::FN_OR:  o_aluc = pipe_pkg::ALUC_OR;
					pipe_pkg::FN_XOR: o_aluc = pipe_pkg::ALUC_XOR;
					pipe_pkg::FN_SLL: o_aluc = pipe_pkg::ALUC_SLL;
					pipe_pkg::FN_SRL: o_aluc = pipe_pkg::ALUC_SRL;
					pipe_pkg::FN_SRA: o_aluc = pipe_pkg::ALUC_SRA;
					default:          o_wreg = 1'b0;
				endcase
				o_shift = (i_inst.r.funct == pipe_pkg::FN_SLL) ||
					(i_inst.r.funct == pipe_pkg::FN_SRL) ||
					(i_inst.r.funct == pipe_pkg::FN_SRA);
			end
			pipe_pkg::OP_ADDI,
			pipe_pkg::OP_ANDI,
			pipe_pkg::OP_ORI,
			pipe_pkg::OP_XORI,
			pipe_pkg::OP_LUI:
			begin
				o_wreg   = 1'b1;
				o_aluimm = 1'b1;
				o_regrt  = 1'b1;
				// only addi sign-extends
				o_sext   = (i_inst.i.op == pipe_pkg::OP_ADDI);
				case (i_inst.i.op)
					pipe_pkg::OP_ANDI: o_aluc = pipe_pkg::ALUC_AND;
					pipe_pkg::OP_ORI:  o_aluc = pipe_pkg::ALUC_OR;
					pipe_pkg::OP_XORI: o_aluc = pipe_pkg::ALUC_XOR;
					pipe_pkg::OP_LUI:  o_aluc = pipe_pkg::ALUC_LUI;
					default:           o_aluc = pipe_pkg::ALUC_ADD;
				endcase
			end
			default:
			begin
				o_wreg = 1'b0;
			end
		endcase
	end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                        clock,
	input  logic                        clrn,
	input  logic                        i_inst_valid,
	input  logic [pipe_pkg::DATA_W-1:0] i_inst,
	id_ex_if.src                        o_id_ex,
	bypass_if.dst                       i_bypass
);

	logic                          if_valid;
	pipe_pkg::inst_t               if_inst;
	logic [pipe_pkg::ALUC_W-1:0]   aluc;
	logic                          aluimm;
	logic                          shift;
	logic                          regrt;
	logic                          sext;
	logic                          wreg;
	logic [pipe_pkg::REG_AW-1:0]   rs;
	logic [pipe_pkg::REG_AW-1:0]   rt;
	logic [pipe_pkg::REG_AW-1:0]   rn;
	logic [pipe_pkg::DATA_W-1:0]   qa;
	logic [pipe_pkg::DATA_W-1:0]   qb;
	logic [pipe_pkg::DATA_W-1:0]   fwd_a;
	logic [pipe_pkg::DATA_W-1:0]   fwd_b;
	logic [pipe_pkg::DATA_W-1:0]   ext_imm;
	logic                          wr_flag;

	// if/id register takes every strobe
	always_ff @(posedge clock or negedge clrn)
	begin
		if (!clrn)
		begin
			if_valid <= 1'b0;
			if_inst  <= '0;
		end
		else
		begin
			if_valid <= i_inst_valid;
			if_inst  <= i_inst;
		end
	end

	ctrl_decode u_ctrl (
		.i_inst   (if_inst),
		.o_aluc   (aluc),
		.o_aluimm (aluimm),
		.o_shift  (shift),
		.o_regrt  (regrt),
		.o_sext   (sext),
		.o_wreg   (wreg)
	);

	assign rs = if_inst.r.rs;
	assign rt = if_inst.r.rt;

	// wb triple drives the write port
	reg_file u_rf (
		.clock (clock),
		.clrn  (clrn),
		.i_rna (rs),
		.i_rnb (rt),
		.i_we  (i_bypass.w_wr),
		.i_wn  (i_bypass.w_rn),
		.i_d   (i_bypass.w_d),
		.o_qa  (qa),
		.o_qb  (qb)
	);

	assign rn      = regrt ? rt : if_inst.r.rd;
	assign ext_imm = {{16{sext & if_inst.i.imm[15]}}, if_inst.i.imm};
	// only place the zero destination is checked
	assign wr_flag = if_valid & wreg & (rn != '0);

	// nearest producer wins
	assign fwd_a = (i_bypass.e_wr && i_bypass.e_rn == rs) ? i_bypass.e_d :
		(i_bypass.m_wr && i_bypass.m_rn == rs) ? i_bypass.m_d : qa;
	assign fwd_b = (i_bypass.e_wr && i_bypass.e_rn == rt) ? i_bypass.e_d :
		(i_bypass.m_wr && i_bypass.m_rn == rt) ? i_bypass.m_d : qb;

	// id/ex register
	always_ff @(posedge clock or negedge clrn)
	begin
		if (!clrn)
		begin
			o_id_ex.valid  <= 1'b0;
			o_id_ex.rn     <= '0;
			o_id_ex.aluc   <= '0;
			o_id_ex.aluimm <= 1'b0;
			o_id_ex.a      <= '0;
			o_id_ex.b      <= '0;
			o_id_ex.imm    <= '0;
		end
		else
		begin
			o_id_ex.valid  <= wr_flag;
			o_id_ex.rn     <= rn;
			o_id_ex.aluc   <= aluc;
			o_id_ex.aluimm <= aluimm;
			// shifts take sa from the instruction, not rs
			o_id_ex.a      <= shift ?
				{{(pipe_pkg::DATA_W - pipe_pkg::SHAMT_W){1'b0}}, if_inst.r.shamt} : fwd_a;
			o_id_ex.b      <= fwd_b;
			o_id_ex.imm    <= ext_imm;
		end
	end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                        clock,
	input  logic                        clrn,
	id_ex_if.dst                        i_id_ex,
	bypass_if.src                       o_bypass,
	output logic                        o_wb_valid,
	output logic [pipe_pkg::REG_AW-1:0] o_wb_reg,
	output logic [pipe_pkg::DATA_W-1:0] o_wb_data
);

	logic [pipe_pkg::DATA_W-1:0] alu_b;
	logic [pipe_pkg::DATA_W-1:0] ealu;
	logic                        m_valid;
	logic [pipe_pkg::REG_AW-1:0] m_rn;
	logic [pipe_pkg::DATA_W-1:0] m_alu;
	logic                        w_valid;
	logic [pipe_pkg::REG_AW-1:0] w_rn;
	logic [pipe_pkg::DATA_W-1:0] w_alu;

	assign alu_b = i_id_ex.aluimm ? i_id_ex.imm : i_id_ex.b;

	alu u_alu (
		.i_a    (i_id_ex.a),
		.i_b    (alu_b),
		.i_aluc (i_id_ex.aluc),
		.o_r    (ealu)
	);

	// ex/mem then mem/wb with no memory access in between
	always_ff @(posedge clock or negedge clrn)
	begin
		if (!clrn)
		begin
			m_valid <= 1'b0;
			m_rn    <= '0;
			m_alu   <= '0;
			w_valid <= 1'b0;
			w_rn    <= '0;
			w_alu   <= '0;
		end
		else
		begin
			m_valid <= i_id_ex.valid;
			m_rn    <= i_id_ex.rn;
			m_alu   <= ealu;
			w_valid <= m_valid;
			w_rn    <= m_rn;
			w_alu   <= m_alu;
		end
	end

	// exe result goes back before it is registered
	assign o_bypass.e_wr = i_id_ex.valid;
	assign o_bypass.e_rn = i_id_ex.rn;
	assign o_bypass.e_d  = ealu;
	assign o_bypass.m_wr = m_valid;
	assign o_bypass.m_rn = m_rn;
	assign o_bypass.m_d  = m_alu;
	assign o_bypass.w_wr = w_valid;
	assign o_bypass.w_rn = w_rn;
	assign o_bypass.w_d  = w_alu;

	assign o_wb_valid = w_valid;
	assign o_wb_reg   = w_rn;
	assign o_wb_data  = w_alu;

endmodule

// ==== rtl/pipe_top.sv ====
`timescale 1ns/1ps

module pipe_top (
	input  logic                        clock,
	input  logic                        clrn,
	input  logic                        i_inst_valid,
	input  logic [pipe_pkg::DATA_W-1:0] i_inst,
	output logic                        o_wb_valid,
	output logic [pipe_pkg::REG_AW-1:0] o_wb_reg,
	output logic [pipe_pkg::DATA_W-1:0] o_wb_data
);

	id_ex_if  id_ex ();
	bypass_if bypass ();

	// if/id, register read, forwarding
	decode_stage u_decode (
		.clock        (clock),
		.clrn         (clrn),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.o_id_ex      (id_ex.src),
		.i_bypass     (bypass.dst)
	);

	// alu plus ex/mem and mem/wb levels
	execute_stage u_execute (
		.clock      (clock),
		.clrn       (clrn),
		.i_id_ex    (id_ex.dst),
		.o_bypass   (bypass.src),
		.o_wb_valid (o_wb_valid),
		.o_wb_reg   (o_wb_reg),
		.o_wb_data  (o_wb_data)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic o_clock,
	output logic o_clrn
);

	localparam int HALF_NS      = 2;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		o_clock = 1'b0;
		forever
			#HALF_NS o_clock = ~o_clock;
	end

	// release on a rising edge, after the flops have sampled it
	initial
	begin
		o_clrn = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge o_clock);
		o_clrn <= 1'b1;
	end

endmodule

// ==== tests/pipe_tb.sv ====
`timescale 1ns/1ps

module pipe_tb;

	localparam int PERIOD_NS    = 4;
	localparam int RESET_CYCLES = 4;
	localparam int SEED         = 24171;
	localparam int N_IDLE       = 5;
	localparam int N_ZERO       = 31;
	localparam int N_BUILD      = 62;
	localparam int N_RTYPE      = 40;
	localparam int N_IMM        = 40;
	localparam int N_SHIFT      = 30;
	localparam int N_DEP        = 60;
	localparam int N_MISC       = 5;
	localparam int DRAIN        = 8;
	localparam int MARGIN       = 20;
	localparam int STIM_CYCLES  = N_IDLE + N_ZERO + N_BUILD + N_RTYPE + N_IMM + N_SHIFT
		+ N_DEP + N_MISC;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + MARGIN;

	localparam logic [5:0] ALU_FN [0:4] = '{pipe_pkg::FN_ADD, pipe_pkg::FN_SUB,
		pipe_pkg::FN_AND, pipe_pkg::FN_OR, pipe_pkg::FN_XOR};
	localparam logic [5:0] SHIFT_FN [0:2] = '{pipe_pkg::FN_SLL, pipe_pkg::FN_SRL,
		pipe_pkg::FN_SRA};
	localparam logic [5:0] IMM_OP [0:4] = '{pipe_pkg::OP_ADDI, pipe_pkg::OP_ANDI,
		pipe_pkg::OP_ORI, pipe_pkg::OP_XORI, pipe_pkg::OP_LUI};

	typedef logic [31:0] model_t [0:31];

	logic        clock;
	logic        clrn;
	logic        inst_valid;
	logic [31:0] inst;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	model_t      model;
	logic [4:0]  exp_reg [$];
	logic [31:0] exp_data [$];
	int          exp_cycle [$];
	int          cycle = 0;
	int          due;
	integer      seed = SEED;
	int          value_errors = 0;
	int          other_errors = 0;
	int          checked = 0;

	tb_clock u_clock (
		.o_clock (clock),
		.o_clrn  (clrn)
	);

	pipe_top DUT (
		.clock        (clock),
		.clrn         (clrn),
		.i_inst_valid (inst_valid),
		.i_inst       (inst),
		.o_wb_valid   (wb_valid),
		.o_wb_reg     (wb_reg),
		.o_wb_data    (wb_data)
	);

	always @(posedge clock)
		cycle <= cycle + 1;

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// r1 to r31
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = rand_word();
		return 5'(1 + r % 31);
	endfunction

	function automatic logic [31:0] make_rtype(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
		pipe_pkg::inst_t w;
		w.r.op    = pipe_pkg::OP_RTYPE;
		w.r.rs    = rs;
		w.r.rt    = rt;
		w.r.rd    = rd;
		w.r.shamt = sa;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic logic [31:0] make_itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		pipe_pkg::inst_t w;
		w.i.op  = op;
		w.i.rs  = rs;
		w.i.rt  = rt;
		w.i.imm = imm;
		return w;
	endfunction

	// expected write flag, destination and value of one instruction
	function automatic logic predict(input pipe_pkg::inst_t word, input model_t regs,
		output logic [4:0] dest, output logic [31:0] value);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] zimm;
		logic [31:0] simm;
		logic        ok;
		a     = regs[word.r.rs];
		b     = regs[word.r.rt];
		zimm  = {16'h0000, word.i.imm};
		simm  = {{16{word.i.imm[15]}}, word.i.imm};
		ok    = 1'b1;
		dest  = word.r.rd;
		value = '0;
		if (word.r.op == pipe_pkg::OP_RTYPE)
		begin
			case (word.r.funct)
				pipe_pkg::FN_ADD: value = a + b;
				pipe_pkg::FN_SUB: value = a - b;
				pipe_pkg::FN_AND: value = a & b;
				pipe_pkg::FN_OR:  value = a | b;
				pipe_pkg::FN_XOR: value = a ^ b;
				pipe_pkg::FN_SLL: value = b << word.r.shamt;
				pipe_pkg::FN_SRL: value = b >> word.r.shamt;
				pipe_pkg::FN_SRA: value = $signed(b) >>> word.r.shamt;
				default:          ok = 1'b0;
			endcase
		end
		else
		begin
			dest = word.i.rt;
			case (word.i.op)
				pipe_pkg::OP_ADDI: value = a + simm;
				pipe_pkg::OP_ANDI: value = a & zimm;
				pipe_pkg::OP_ORI:  value = a | zimm;
				pipe_pkg::OP_XORI: value = a ^ zimm;
				pipe_pkg::OP_LUI:  value = {word.i.imm, 16'h0000};
				default:           ok = 1'b0;
			endcase
		end
		return ok && (dest != 5'd0);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("Fail %s got 0x%08h expected 0x%08h at cycle %0d", name, got, want, cycle);
			value_errors++;
		end
	endtask

	// one strobe; the model follows issue order
	task automatic issue(input logic [31:0] word);
		logic [4:0]  dest;
		logic [31:0] value;
		logic        wr;
		@(posedge clock);
		inst_valid <= 1'b1;
		inst       <= word;
		wr = predict(word, model, dest, value);
		if (wr)
		begin
			model[dest] = value;
			exp_reg.push_back(dest);
			exp_data.push_back(value);
			// strobe edge plus four
			exp_cycle.push_back(cycle + 5);
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clock);
			inst_valid <= 1'b0;
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d value mismatches, %0d other, %0d writebacks compared",
			value_errors, other_errors, checked);
	endtask

	// outputs are stable on the falling edge
	always @(negedge clock)
	begin
		if (wb_valid === 1'b1)
		begin
			if (exp_reg.size() == 0)
			begin
				$display("Error: writeback to r%0d at cycle %0d with nothing outstanding",
					wb_reg, cycle);
				other_errors++;
			end
			else
			begin
				due = exp_cycle.pop_front();
				check("o_wb_reg", 32'(wb_reg), 32'(exp_reg.pop_front()));
				check("o_wb_data", wb_data, exp_data.pop_front());
				if (cycle != due)
				begin
					$display("Error: writeback came at cycle %0d, expected at cycle %0d",
						cycle, due);
					other_errors++;
				end
				checked++;
			end
		end
	end

	initial
	begin
		#(TIMEOUT_CYCLES * PERIOD_NS);
		$display("Error: timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		other_errors++;
		print_counts();
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] rnd;
		logic [4:0]  x;
		logic [4:0]  y;
		logic [2:0]  sel;
		inst_valid = 1'b0;
		inst       = '0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		@(posedge clrn);
		idle(N_IDLE);

		// every register reads zero before any write
		for (int i = 1; i <= 31; i++)
			issue(make_rtype(pipe_pkg::FN_ADD, 5'(i), 5'(i), 5'(i), 5'd0));

		// random contents through lui then ori
		for (int i = 1; i <= 31; i++)
		begin
			rnd = rand_word();
			issue(make_itype(pipe_pkg::OP_LUI, 5'd0, 5'(i), rnd[31:16]));
			issue(make_itype(pipe_pkg::OP_ORI, 5'(i), 5'(i), rnd[15:0]));
		end

		repeat (N_RTYPE)
		begin
			rnd = rand_word();
			sel = 3'(rnd % 5);
			issue(make_rtype(ALU_FN[sel], pick_reg(), pick_reg(), pick_reg(), 5'd0));
		end

		// half the immediates are negative
		repeat (N_IMM)
		begin
			rnd = rand_word();
			sel = 3'(rnd[31:16] % 5);
			issue(make_itype(IMM_OP[sel], pick_reg(), pick_reg(), rnd[15:0]));
		end

		repeat (N_SHIFT)
		begin
			rnd = rand_word();
			sel = 3'(rnd[31:16] % 3);
			issue(make_rtype(SHIFT_FN[sel], 5'd0, pick_reg(), pick_reg(), rnd[4:0]));
		end

		// producer, d-1 fillers, consumer; gap 1 doubles the distance
		for (int d = 1; d <= 5; d++)
		begin
			for (int g = 0; g <= 1; g++)
			begin
				x   = pick_reg();
				rnd = rand_word();
				issue(make_itype(pipe_pkg::OP_ADDI, pick_reg(), x, rnd[15:0]));
				idle(g);
				for (int f = 1; f < d; f++)
				begin
					y   = 5'(x % 31 + 1);
					rnd = rand_word();
					sel = 3'(rnd % 5);
					issue(make_rtype(ALU_FN[sel], pick_reg(), pick_reg(), y, 5'd0));
					idle(g);
				end
				rnd = rand_word();
				sel = 3'(rnd % 5);
				issue(make_rtype(ALU_FN[sel], x, (d % 2 == 1) ? x : pick_reg(), pick_reg(),
					5'd0));
				idle(g);
			end
		end

		// no writeback expected for these four
		issue(make_itype(pipe_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234));
		issue(make_rtype(pipe_pkg::FN_ADD, 5'd1, 5'd2, 5'd0, 5'd0));
		issue(make_itype(6'b100011, 5'd1, 5'd2, 16'h0010));
		issue(make_rtype(6'b001000, 5'd1, 5'd0, 5'd3, 5'd0));
		issue(make_rtype(pipe_pkg::FN_ADD, 5'd0, 5'd0, 5'd5, 5'd0));
		idle(DRAIN);

		if (exp_reg.size() != 0)
		begin
			$display("Error: %0d expected writebacks never arrived", exp_reg.size());
			other_errors++;
		end
		print_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/pipe_pkg.sv
rtl/pipe_if.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/ctrl_decode.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/pipe_top.sv
tests/tb_clock.sv
tests/pipe_tb.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

SOURCES := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vpipe_tb: vlog.f $(SOURCES)
	verilator --binary --timing --top-module pipe_tb -f vlog.f -o Vpipe_tb

run: obj_dir/Vpipe_tb
	./obj_dir/Vpipe_tb | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module pipe_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log
